// File: rtl/isaPkg.sv
package isaPkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 2 ** REG_ADDR_W;
	localparam int OPCODE_W = 6;
	localparam int SHAMT_W = 5;
	localparam int FUNCT_W = 6;
	localparam int IMM_W = 16;
	localparam int JIDX_W = 26;

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	localparam int MEM_AW = $clog2(IMEM_DEPTH); // Word index from byte address bits 7:2

	// Opcodes
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h00;
	localparam logic [OPCODE_W-1:0] OP_J     = 6'h02;
	localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'h04;
	localparam logic [OPCODE_W-1:0] OP_BNE   = 6'h05;
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'h08;
	localparam logic [OPCODE_W-1:0] OP_ADDIU = 6'h09;
	localparam logic [OPCODE_W-1:0] OP_SLTI  = 6'h0a;
	localparam logic [OPCODE_W-1:0] OP_SLTIU = 6'h0b;
	localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'h0c;
	localparam logic [OPCODE_W-1:0] OP_ORI   = 6'h0d;
	localparam logic [OPCODE_W-1:0] OP_XORI  = 6'h0e;
	localparam logic [OPCODE_W-1:0] OP_LUI   = 6'h0f;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'h23;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'h2b;

	// R-type funct codes
	localparam logic [FUNCT_W-1:0] FN_ADD  = 6'h20;
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
	localparam logic [FUNCT_W-1:0] FN_SUB  = 6'h22;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'h24;
	localparam logic [FUNCT_W-1:0] FN_OR   = 6'h25;
	localparam logic [FUNCT_W-1:0] FN_XOR  = 6'h26;
	localparam logic [FUNCT_W-1:0] FN_NOR  = 6'h27;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;
	localparam logic [FUNCT_W-1:0] FN_SLTU = 6'h2b;

	// Immediate is bits 15:0, jump index bits 25:0
	typedef struct packed {
		logic [OPCODE_W-1:0]   opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [SHAMT_W-1:0]    shamt;
		logic [FUNCT_W-1:0]    funct;
	} instrT;

endpackage

// File: rtl/pipePkg.sv
package pipePkg;

	import isaPkg::*;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_LUI
	} aluOpT;

	// All zero is a bubble
	typedef struct packed {
		aluOpT aluOp;
		logic  useImm; // B operand from immediate
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  branchEq;
		logic  branchNe;
	} ctrlT;

	typedef struct packed {
		ctrlT                  ctrl;
		logic [XLEN-1:0]       pc4;
		logic [XLEN-1:0]       rsData;
		logic [XLEN-1:0]       rtData;
		logic [XLEN-1:0]       imm;
		logic [REG_ADDR_W-1:0] destReg;
	} idExT;

	typedef struct packed {
		ctrlT                  ctrl;
		logic [XLEN-1:0]       aluResult;
		logic [XLEN-1:0]       storeData;
		logic [REG_ADDR_W-1:0] destReg;
	} exMemT;

	typedef struct packed {
		logic                  regWrite;
		logic                  memRead;
		logic [XLEN-1:0]       aluResult;
		logic [XLEN-1:0]       loadData;
		logic [REG_ADDR_W-1:0] destReg;
	} memWbT;

	// Back to the register file and out to the retire port
	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] destReg;
		logic [XLEN-1:0]       data;
	} wbT;

endpackage

// File: rtl/pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	always_ff @(posedge clk) begin
		if (rst || flush)
			q <= payloadT'(0); // Bubble
		else
			q <= d;
	end

	// Squashed instruction must leave no trace downstream
	assert property (@(posedge clk) disable iff (rst) flush |=> (q == payloadT'(0)))
		else $error("pipeReg: stage not empty after flush");

endmodule

// File: rtl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import isaPkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              progWe,
	input  logic [MEM_AW-1:0] progAddr,
	input  logic [XLEN-1:0]   progData,
	input  logic              redirect,
	input  logic [XLEN-1:0]   redirectTarget,
	input  logic              flush,
	output instrT             instrId,
	output logic [XLEN-1:0]   pc4Id
);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc4;
	logic [XLEN-1:0] instrMem [IMEM_DEPTH];

	assign pc4 = pc + XLEN'(4);

	always_ff @(posedge clk) begin
		if (rst && progWe)
			instrMem[progAddr] <= progData; // Program load while held in reset
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (redirect)
			pc <= redirectTarget;
		else
			pc <= pc4;
	end

	// IF/ID
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			instrId <= '0; // Decodes as a NOP
			pc4Id <= '0;
		end else begin
			instrId <= instrT'(instrMem[pc[MEM_AW+1:2]]);
			pc4Id <= pc4;
		end
	end

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import isaPkg::*, pipePkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  instrT           instr,
	input  logic [XLEN-1:0] pc4,
	input  wbT              wb,
	output idExT            idEx,
	output logic            jumpTaken,
	output logic [XLEN-1:0] jumpTarget
);

	logic [XLEN-1:0] regFile [NUM_REGS];
	ctrlT            ctrl;
	logic            zeroExt;
	logic [IMM_W-1:0] immField;
	logic [XLEN-1:0] imm;

	function automatic ctrlT aluCtrl(aluOpT op, logic useImm);
		ctrlT c;
		c = '0;
		c.aluOp = op;
		c.useImm = useImm;
		c.regWrite = 1'b1;
		return c;
	endfunction

	// Writeback lands in the first half of the cycle, so reads see it
	function automatic logic [XLEN-1:0] readReg(logic [REG_ADDR_W-1:0] addr);
		if (wb.valid && wb.destReg == addr && addr != '0)
			return wb.data;
		return regFile[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regFile[i] <= '0;
		end else if (wb.valid && wb.destReg != '0) begin
			regFile[wb.destReg] <= wb.data;
		end
	end

	always_comb begin
		ctrl = '0;
		case (instr.opcode)
			OP_RTYPE: begin
				case (instr.funct)
					FN_ADD, FN_ADDU: ctrl = aluCtrl(ALU_ADD, 1'b0);
					FN_SUB, FN_SUBU: ctrl = aluCtrl(ALU_SUB, 1'b0);
					FN_AND:          ctrl = aluCtrl(ALU_AND, 1'b0);
					FN_OR:           ctrl = aluCtrl(ALU_OR, 1'b0);
					FN_XOR:          ctrl = aluCtrl(ALU_XOR, 1'b0);
					FN_NOR:          ctrl = aluCtrl(ALU_NOR, 1'b0);
					FN_SLT:          ctrl = aluCtrl(ALU_SLT, 1'b0);
					FN_SLTU:         ctrl = aluCtrl(ALU_SLTU, 1'b0);
					default:         ctrl = '0; // Includes the all-zero NOP
				endcase
			end
			OP_ADDI, OP_ADDIU: ctrl = aluCtrl(ALU_ADD, 1'b1);
			OP_ANDI:  ctrl = aluCtrl(ALU_AND, 1'b1);
			OP_ORI:   ctrl = aluCtrl(ALU_OR, 1'b1);
			OP_XORI:  ctrl = aluCtrl(ALU_XOR, 1'b1);
			OP_SLTI:  ctrl = aluCtrl(ALU_SLT, 1'b1);
			OP_SLTIU: ctrl = aluCtrl(ALU_SLTU, 1'b1);
			OP_LUI:   ctrl = aluCtrl(ALU_LUI, 1'b1);
			OP_LW: begin
				ctrl = aluCtrl(ALU_ADD, 1'b1);
				ctrl.memRead = 1'b1;
			end
			OP_SW: begin
				ctrl.aluOp = ALU_ADD;
				ctrl.useImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			OP_BEQ: ctrl.branchEq = 1'b1;
			OP_BNE: ctrl.branchNe = 1'b1;
			default: ctrl = '0; // J and unknown codes
		endcase
	end

	assign zeroExt = (instr.opcode == OP_ANDI) || (instr.opcode == OP_ORI) ||
		(instr.opcode == OP_XORI);
	assign immField = instr[IMM_W-1:0];
	assign imm = zeroExt ? {{(XLEN-IMM_W){1'b0}}, immField} :
		{{(XLEN-IMM_W){immField[IMM_W-1]}}, immField};

	assign idEx.ctrl = ctrl;
	assign idEx.pc4 = pc4;
	assign idEx.rsData = readReg(instr.rs);
	assign idEx.rtData = readReg(instr.rt);
	assign idEx.imm = imm;
	assign idEx.destReg = (instr.opcode == OP_RTYPE) ? instr.rd : instr.rt;

	assign jumpTaken = (instr.opcode == OP_J);
	assign jumpTarget = {pc4[XLEN-1:XLEN-4], instr[JIDX_W-1:0], 2'b00};

	// r0 must survive any writeback sequence
	assert property (@(posedge clk) disable iff (rst) regFile[0] == '0)
		else $error("decodeStage: register 0 was written");

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage import isaPkg::*, pipePkg::*; (
	input  idExT            idEx,
	output exMemT           exMem,
	output logic            branchTaken,
	output logic [XLEN-1:0] branchTarget
);

	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] aluResult;
	logic            opEqual;

	assign opA = idEx.rsData;
	assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.rtData;

	always_comb begin
		case (idEx.ctrl.aluOp)
			ALU_ADD:  aluResult = opA + opB;
			ALU_SUB:  aluResult = opA - opB;
			ALU_AND:  aluResult = opA & opB;
			ALU_OR:   aluResult = opA | opB;
			ALU_XOR:  aluResult = opA ^ opB;
			ALU_NOR:  aluResult = ~(opA | opB);
			ALU_SLT:  aluResult = XLEN'($signed(opA) < $signed(opB));
			ALU_SLTU: aluResult = XLEN'(opA < opB);
			ALU_LUI:  aluResult = {opB[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}};
			default:  aluResult = '0;
		endcase
	end

	// Branch compares the two registers directly
	assign opEqual = (idEx.rsData == idEx.rtData);
	assign branchTaken = (idEx.ctrl.branchEq && opEqual) || (idEx.ctrl.branchNe && !opEqual);
	assign branchTarget = idEx.pc4 + (idEx.imm << 2);

	assign exMem.ctrl = idEx.ctrl;
	assign exMem.aluResult = aluResult;
	assign exMem.storeData = idEx.rtData;
	assign exMem.destReg = idEx.destReg;

	// Decoder never emits both branch kinds for one instruction
	always_comb begin
		assert (!(idEx.ctrl.branchEq === 1'b1 && idEx.ctrl.branchNe === 1'b1))
			else $error("executeStage: BEQ and BNE set together");
	end

endmodule

// File: rtl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import isaPkg::*, pipePkg::*; (
	input  logic            clk,
	input  exMemT           exMem,
	output logic [XLEN-1:0] loadData,
	output logic            memWrValid,
	output logic [XLEN-1:0] memWrAddr,
	output logic [XLEN-1:0] memWrData
);

	logic [XLEN-1:0]   dataMem [DMEM_DEPTH];
	logic [MEM_AW-1:0] wordAddr;

	assign wordAddr = exMem.aluResult[MEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (exMem.ctrl.memWrite)
			dataMem[wordAddr] <= exMem.storeData;
	end

	assign loadData = dataMem[wordAddr]; // Async read

	// Store trace
	assign memWrValid = exMem.ctrl.memWrite;
	assign memWrAddr = exMem.aluResult;
	assign memWrData = exMem.storeData;

endmodule

// File: rtl/mipsCore.sv
`timescale 1ns/1ps

module mipsCore import isaPkg::*, pipePkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  progWe,
	input  logic [MEM_AW-1:0]     progAddr,
	input  logic [XLEN-1:0]       progData,
	output logic                  wbValid,
	output logic [REG_ADDR_W-1:0] wbReg,
	output logic [XLEN-1:0]       wbData,
	output logic                  memWrValid,
	output logic [XLEN-1:0]       memWrAddr,
	output logic [XLEN-1:0]       memWrData
);

	instrT           instrId;
	logic [XLEN-1:0] pc4Id;
	idExT            idExD, idExQ;
	exMemT           exMemD, exMemQ;
	memWbT           memWbD, memWbQ;
	wbT              wb;
	logic            jumpTaken, branchTaken;
	logic [XLEN-1:0] jumpTarget, branchTarget;
	logic            redirect;
	logic [XLEN-1:0] redirectTarget;
	logic [XLEN-1:0] loadData;

	// Branch in EX is older than a jump in ID
	assign redirect = branchTaken || jumpTaken;
	assign redirectTarget = branchTaken ? branchTarget : jumpTarget;

	fetchStage i_fetch (
		.clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.redirect(redirect), .redirectTarget(redirectTarget), .flush(redirect),
		.instrId(instrId), .pc4Id(pc4Id)
	);

	decodeStage i_decode (
		.clk(clk), .rst(rst), .instr(instrId), .pc4(pc4Id), .wb(wb),
		.idEx(idExD), .jumpTaken(jumpTaken), .jumpTarget(jumpTarget)
	);

	pipeReg #(.payloadT(idExT)) i_idEx (
		.clk(clk), .rst(rst), .flush(branchTaken), .d(idExD), .q(idExQ)
	);

	executeStage i_execute (
		.idEx(idExQ), .exMem(exMemD), .branchTaken(branchTaken), .branchTarget(branchTarget)
	);

	pipeReg #(.payloadT(exMemT)) i_exMem (
		.clk(clk), .rst(rst), .flush(1'b0), .d(exMemD), .q(exMemQ)
	);

	dataMemory i_dmem (
		.clk(clk), .exMem(exMemQ), .loadData(loadData),
		.memWrValid(memWrValid), .memWrAddr(memWrAddr), .memWrData(memWrData)
	);

	assign memWbD.regWrite = exMemQ.ctrl.regWrite;
	assign memWbD.memRead = exMemQ.ctrl.memRead;
	assign memWbD.aluResult = exMemQ.aluResult;
	assign memWbD.loadData = loadData;
	assign memWbD.destReg = exMemQ.destReg;

	pipeReg #(.payloadT(memWbT)) i_memWb (
		.clk(clk), .rst(rst), .flush(1'b0), .d(memWbD), .q(memWbQ)
	);

	// Writeback mux
	assign wb.valid = memWbQ.regWrite && (memWbQ.destReg != '0); // r0 writes never retire
	assign wb.destReg = memWbQ.destReg;
	assign wb.data = memWbQ.memRead ? memWbQ.loadData : memWbQ.aluResult;

	assign wbValid = wb.valid;
	assign wbReg = wb.destReg;
	assign wbData = wb.data;

endmodule

// File: verification/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// One program word per row in word-index order
// Each event row holds name, kind, register or byte address and value

typedef enum bit {EV_RETIRE, EV_STORE} evKindT;

typedef struct packed {
	evKindT          kind;
	logic [XLEN-1:0] addr;
	logic [XLEN-1:0] value;
} eventT;

logic [XLEN-1:0] progWords [$];
eventT           expEvents [$];
string           expNames [$];

function automatic logic [XLEN-1:0] rType(int rs, int rt, int rd, logic [5:0] fn);
	return {OP_RTYPE, REG_ADDR_W'(rs), REG_ADDR_W'(rt), REG_ADDR_W'(rd), 5'd0, fn};
endfunction

function automatic logic [XLEN-1:0] iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
	return {op, REG_ADDR_W'(rs), REG_ADDR_W'(rt), imm};
endfunction

function automatic logic [XLEN-1:0] jType(int wordIdx);
	return {OP_J, 26'(wordIdx)};
endfunction

function automatic void addEvent(string name, evKindT kind, logic [XLEN-1:0] addr,
	logic [XLEN-1:0] value);
	expEvents.push_back('{kind, addr, value});
	expNames.push_back(name);
endfunction

// At least three instructions between a producer and its consumer
function automatic void buildProgram();
	progWords.push_back(iType(OP_ADDIU, 0, 1, 16'h7fff));  // 0
	progWords.push_back(iType(OP_ADDI, 0, 2, 16'hffff));   // Sign-extends to -1
	progWords.push_back(iType(OP_LUI, 0, 3, 16'h8000));
	progWords.push_back(iType(OP_ORI, 0, 4, 16'hf0f0));
	progWords.push_back(iType(OP_XORI, 1, 6, 16'hffff));   // 4
	progWords.push_back(rType(1, 2, 5, FN_ADDU));
	progWords.push_back(rType(3, 1, 7, FN_SLT));           // Top bit set on rs
	progWords.push_back(rType(3, 1, 8, FN_SLTU));
	progWords.push_back(rType(1, 4, 9, FN_SUB));           // 8
	progWords.push_back(rType(2, 4, 10, FN_AND));
	progWords.push_back(rType(3, 4, 11, FN_OR));
	progWords.push_back(rType(2, 4, 12, FN_XOR));
	progWords.push_back(rType(1, 4, 13, FN_NOR));          // 12
	progWords.push_back(iType(OP_SLTI, 2, 14, 16'h0001));
	progWords.push_back(iType(OP_SLTIU, 1, 15, 16'hffff)); // Compares against 0xffffffff
	progWords.push_back(iType(OP_ANDI, 2, 16, 16'h8001));
	progWords.push_back(rType(1, 6, 17, FN_ADD));          // 16
	progWords.push_back(rType(0, 1, 18, FN_SUBU));
	progWords.push_back(iType(OP_SW, 0, 11, 16'h0008));
	progWords.push_back(iType(OP_SW, 0, 12, 16'h000c));
	progWords.push_back(iType(OP_ADDIU, 1, 0, 16'h0005));  // 20 writes r0
	progWords.push_back(iType(OP_LW, 0, 19, 16'h0008));
	progWords.push_back(iType(OP_LW, 0, 20, 16'h000c));
	progWords.push_back(iType(OP_BEQ, 14, 15, 16'h0002));  // Taken to 26
	progWords.push_back(iType(OP_ADDIU, 0, 21, 16'h0111)); // 24 is skipped
	progWords.push_back(iType(OP_ADDIU, 0, 22, 16'h0222)); // Skipped
	progWords.push_back(iType(OP_BNE, 7, 8, 16'h0002));    // Taken to 29
	progWords.push_back(iType(OP_ADDIU, 0, 21, 16'h0333)); // Skipped
	progWords.push_back(iType(OP_ADDIU, 0, 22, 16'h0444)); // 28 is skipped
	progWords.push_back(iType(OP_BEQ, 7, 8, 16'h0002));    // Not taken
	progWords.push_back(iType(OP_ADDIU, 0, 23, 16'h0555));
	progWords.push_back(iType(OP_BNE, 14, 15, 16'h0005));  // Not taken
	progWords.push_back(iType(OP_ADDIU, 0, 24, 16'h0666)); // 32
	progWords.push_back(jType(35));
	progWords.push_back(iType(OP_ADDIU, 0, 25, 16'h0777)); // Skipped by the jump
	progWords.push_back(iType(OP_ADDIU, 19, 26, 16'h0001));
	progWords.push_back(jType(36));                         // 36 loops on itself
endfunction

// Program order; a retire precedes a store that lands in the same cycle
function automatic void buildEvents();
	addEvent("addiu", EV_RETIRE, 1, 32'h0000_7fff);
	addEvent("addi sext", EV_RETIRE, 2, 32'hffff_ffff);
	addEvent("lui", EV_RETIRE, 3, 32'h8000_0000);
	addEvent("ori zext", EV_RETIRE, 4, 32'h0000_f0f0);
	addEvent("xori zext", EV_RETIRE, 6, 32'h0000_8000);
	addEvent("addu wrap", EV_RETIRE, 5, 32'h0000_7ffe);
	addEvent("slt signed", EV_RETIRE, 7, 32'h0000_0001);
	addEvent("sltu unsigned", EV_RETIRE, 8, 32'h0000_0000);
	addEvent("sub", EV_RETIRE, 9, 32'hffff_8f0f);
	addEvent("and", EV_RETIRE, 10, 32'h0000_f0f0);
	addEvent("or", EV_RETIRE, 11, 32'h8000_f0f0);
	addEvent("xor", EV_RETIRE, 12, 32'hffff_0f0f);
	addEvent("nor", EV_RETIRE, 13, 32'hffff_0000);
	addEvent("slti", EV_RETIRE, 14, 32'h0000_0001);
	addEvent("sltiu sext", EV_RETIRE, 15, 32'h0000_0001);
	addEvent("andi zext", EV_RETIRE, 16, 32'h0000_8001);
	addEvent("add", EV_RETIRE, 17, 32'h0000_ffff);
	addEvent("subu", EV_RETIRE, 18, 32'hffff_8001);
	addEvent("sw 8", EV_STORE, 32'h0000_0008, 32'h8000_f0f0);
	addEvent("sw 12", EV_STORE, 32'h0000_000c, 32'hffff_0f0f);
	addEvent("lw 8 after r0 write", EV_RETIRE, 19, 32'h8000_f0f0);
	addEvent("lw 12", EV_RETIRE, 20, 32'hffff_0f0f);
	addEvent("beq not taken", EV_RETIRE, 23, 32'h0000_0555);
	addEvent("bne not taken", EV_RETIRE, 24, 32'h0000_0666);
	addEvent("j target", EV_RETIRE, 26, 32'h8000_f0f1);
endfunction

`endif

// File: verification/coreTb.sv
`timescale 1ns/1ps

module coreTb import isaPkg::*; ();

	logic                  clk;
	logic                  rst;
	logic                  progWe;
	logic [MEM_AW-1:0]     progAddr;
	logic [XLEN-1:0]       progData;
	logic                  wbValid;
	logic [REG_ADDR_W-1:0] wbReg;
	logic [XLEN-1:0]       wbData;
	logic                  memWrValid;
	logic [XLEN-1:0]       memWrAddr;
	logic [XLEN-1:0]       memWrData;

	int evIdx;
	int passCount;
	int failCount;

	`include "programTable.svh"

	mipsCore i_dut (
		.clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.memWrValid(memWrValid), .memWrAddr(memWrAddr), .memWrData(memWrData)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Match one observed event with the next table row
	task automatic checkEvent(evKindT kind, logic [XLEN-1:0] addr, logic [XLEN-1:0] value);
		eventT exp;
		string name;
		if (evIdx >= expEvents.size()) begin
			$display("unexpected %s event at %h with %h after the last row", kind.name(),
				addr, value);
			failCount++;
		end else begin
			exp = expEvents[evIdx];
			name = expNames[evIdx];
			evIdx++;
			if (exp.kind !== kind) begin
				$display("%s: expected a %s event but a %s event arrived", name,
					exp.kind.name(), kind.name());
				failCount++;
			end else if (exp.addr !== addr) begin
				$display("mismatch %s location expected %h actual %h", name, exp.addr, addr);
				failCount++;
			end else if (exp.value !== value) begin
				$display("mismatch %s expected %h actual %h", name, exp.value, value);
				failCount++;
			end else begin
				$display("ok %s", name);
				passCount++;
			end
		end
	endtask

	task automatic reportQuiet(string name, logic quiet);
		if (quiet) begin
			$display("ok %s", name);
			passCount++;
		end else begin
			$display("%s: an event appeared while the core should be idle", name);
			failCount++;
		end
	endtask

	initial begin
		int   idle;
		logic quiet;
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		evIdx = 0;
		passCount = 0;
		failCount = 0;
		buildProgram();
		buildEvents();

		for (int i = 0; i < IMEM_DEPTH; i++) begin
			@(posedge clk);
			progWe <= 1'b1;
			progAddr <= MEM_AW'(i);
			progData <= (i < progWords.size()) ? progWords[i] : '0; // NOP past the program
		end
		@(posedge clk);
		progWe <= 1'b0;

		quiet = 1'b1;
		repeat (3) begin
			@(negedge clk);
			if (wbValid !== 1'b0 || memWrValid !== 1'b0)
				quiet = 1'b0;
		end
		reportQuiet("reset idle", quiet);
		@(posedge clk);
		rst <= 1'b0;

		// Outputs settle after the rising edge, so sample on the falling one
		idle = 0;
		while (evIdx < expEvents.size() && idle < 200) begin
			@(negedge clk);
			idle++;
			if (wbValid) begin
				checkEvent(EV_RETIRE, XLEN'(wbReg), wbData);
				idle = 0;
			end
			if (memWrValid) begin
				checkEvent(EV_STORE, memWrAddr, memWrData);
				idle = 0;
			end
		end

		if (evIdx < expEvents.size()) begin
			$display("timeout: %s did not arrive within 200 cycles", expNames[evIdx]);
			failCount++;
		end else begin
			quiet = 1'b1;
			repeat (50) begin
				@(negedge clk);
				if (wbValid !== 1'b0 || memWrValid !== 1'b0)
					quiet = 1'b0;
			end
			reportQuiet("self loop quiet", quiet);
		end

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+verification
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/pipeReg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/dataMemory.sv
rtl/mipsCore.sv
verification/coreTb.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module coreTb -o coreTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/coreTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi
exit 0
